// File: design/mesh_config.svh
`ifndef MESH_CONFIG_SVH
`define MESH_CONFIG_SVH

// 2x2 mesh, node n sits at x = n % MESH_X, y = n / MESH_X.
`define MESH_X 2
`define MESH_Y 2
`define NODE_BITS 2

`define MEM_WORDS 64 // 32-bit words per scratchpad.
`define APB_AW 10

`endif

// File: design/mesh_pkg.sv
package mesh_pkg;

  typedef enum logic [1:0] {
    PKT_RD_REQ = 2'd0,
    PKT_WR_REQ = 2'd1,
    PKT_RD_RSP = 2'd2,
    PKT_WR_RSP = 2'd3
  } pkt_kind_e;

  // router port numbers.
  localparam logic [2:0] PORT_LOCAL = 3'd0;
  localparam logic [2:0] PORT_EAST  = 3'd1; // x + 1.
  localparam logic [2:0] PORT_WEST  = 3'd2;
  localparam logic [2:0] PORT_NORTH = 3'd3; // y + 1.
  localparam logic [2:0] PORT_SOUTH = 3'd4;

  typedef struct packed {
    logic [19:0] rsvd;
    logic [5:0]  addr;
    pkt_kind_e   kind;
    logic        src_y;
    logic        src_x;
    logic        dst_y;
    logic        dst_x;
  } flit_hdr_t;

  // first flit is read as header, second as data.
  typedef union packed {
    flit_hdr_t   hdr;
    logic [31:0] data;
  } flit_payload_u;

  typedef struct packed {
    flit_payload_u payload;
    logic          last;
  } flit_t;

  typedef struct packed {
    flit_t flit;
    logic  valid;
  } link_t;

endpackage

// File: design/noc_router.sv
`timescale 1ns/100ps

module noc_router #(
  parameter int POS_X = 0,
  parameter int POS_Y = 0
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  mesh_pkg::link_t [4:0] in_link_i,
  output logic [4:0]            in_ready_o,
  output mesh_pkg::link_t [4:0] out_link_o,
  input  logic [4:0]            out_ready_i
);

  localparam int NPORT = 5;

  mesh_pkg::flit_t [NPORT-1:0] buf_flit_q;
  logic [NPORT-1:0]            buf_vld_q;
  logic [NPORT-1:0]            in_pkt_q;  // header gone, data flit still to follow.
  logic [NPORT-1:0][2:0]       route;
  logic [NPORT-1:0][NPORT-1:0] req;
  logic [NPORT-1:0]            gnt_vld;
  logic [NPORT-1:0][2:0]       gnt_idx;
  logic [NPORT-1:0]            lock_q;
  logic [NPORT-1:0][2:0]       owner_q;
  logic [NPORT-1:0][2:0]       rr_q;
  logic [NPORT-1:0][2:0]       sel;
  logic [NPORT-1:0]            out_vld;
  logic [NPORT-1:0]            xfer;
  logic [NPORT-1:0]            pop;

  assign in_ready_o = ~buf_vld_q; // one-flit slot per input.

  // x first, then y.
  always_comb begin
    mesh_pkg::flit_hdr_t hdr;
    for (int i = 0; i < NPORT; i++) begin
      hdr = buf_flit_q[i].payload.hdr;
      if (hdr.dst_x > 1'(POS_X)) begin
        route[i] = mesh_pkg::PORT_EAST;
      end else if (hdr.dst_x < 1'(POS_X)) begin
        route[i] = mesh_pkg::PORT_WEST;
      end else if (hdr.dst_y > 1'(POS_Y)) begin
        route[i] = mesh_pkg::PORT_NORTH;
      end else if (hdr.dst_y < 1'(POS_Y)) begin
        route[i] = mesh_pkg::PORT_SOUTH;
      end else begin
        route[i] = mesh_pkg::PORT_LOCAL;
      end
    end
  end

  // only waiting headers compete for a free output.
  always_comb begin
    for (int o = 0; o < NPORT; o++) begin
      for (int i = 0; i < NPORT; i++) begin
        req[o][i] = buf_vld_q[i] & ~in_pkt_q[i] & ~lock_q[o] & (route[i] == 3'(o));
      end
    end
  end

  // round robin, first requester at or after the pointer wins.
  always_comb begin
    int idx;
    for (int o = 0; o < NPORT; o++) begin
      gnt_vld[o] = 1'b0;
      gnt_idx[o] = '0;
      for (int k = NPORT - 1; k >= 0; k--) begin
        idx = (int'(rr_q[o]) + k) % NPORT;
        if (req[o][idx]) begin
          gnt_vld[o] = 1'b1;
          gnt_idx[o] = 3'(idx);
        end
      end
    end
  end

  always_comb begin
    for (int o = 0; o < NPORT; o++) begin
      sel[o]              = lock_q[o] ? owner_q[o] : gnt_idx[o];
      out_vld[o]          = lock_q[o] ? buf_vld_q[owner_q[o]] : gnt_vld[o];
      xfer[o]             = out_vld[o] & out_ready_i[o];
      out_link_o[o].flit  = buf_flit_q[sel[o]];
      out_link_o[o].valid = out_vld[o];
    end
  end

  always_comb begin
    pop = '0;
    for (int o = 0; o < NPORT; o++) begin
      if (xfer[o]) pop[sel[o]] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      buf_vld_q <= '0;
      in_pkt_q  <= '0;
      lock_q    <= '0;
      owner_q   <= '0;
      rr_q      <= '0;
    end else begin
      for (int i = 0; i < NPORT; i++) begin
        if (pop[i]) begin
          buf_vld_q[i] <= 1'b0;
          in_pkt_q[i]  <= ~buf_flit_q[i].last;
        end else if (in_link_i[i].valid && !buf_vld_q[i]) begin
          buf_vld_q[i] <= 1'b1;
        end
      end
      for (int o = 0; o < NPORT; o++) begin
        if (xfer[o] && buf_flit_q[sel[o]].last) begin
          lock_q[o] <= 1'b0; // tail passed.
          rr_q[o]   <= (sel[o] == 3'(NPORT - 1)) ? 3'd0 : sel[o] + 3'd1;
        end else if (xfer[o] || gnt_vld[o]) begin
          lock_q[o]  <= 1'b1; // a granted header keeps its output.
          owner_q[o] <= sel[o];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NPORT; i++) begin
      if (in_link_i[i].valid && !buf_vld_q[i]) buf_flit_q[i] <= in_link_i[i].flit;
    end
  end

endmodule

// File: design/noc_mesh.sv
`timescale 1ns/100ps
`include "mesh_config.svh"

module noc_mesh (
  input  logic                                       clk,
  input  logic                                       reset_i,
  input  mesh_pkg::link_t [`MESH_X*`MESH_Y-1:0]      local_in_i,
  output logic [`MESH_X*`MESH_Y-1:0]                 local_ready_o,
  output mesh_pkg::link_t [`MESH_X*`MESH_Y-1:0]      local_out_o,
  input  logic [`MESH_X*`MESH_Y-1:0]                 local_ready_i
);

  localparam int NODES = `MESH_X * `MESH_Y;

  mesh_pkg::link_t [NODES-1:0][4:0] r_in;
  logic [NODES-1:0][4:0]            r_in_rdy;
  mesh_pkg::link_t [NODES-1:0][4:0] r_out;
  logic [NODES-1:0][4:0]            r_out_rdy;

  for (genvar yy = 0; yy < `MESH_Y; yy++) begin : g_y
    for (genvar xx = 0; xx < `MESH_X; xx++) begin : g_x
      localparam int N = yy * `MESH_X + xx;

      noc_router #(
        .POS_X (xx),
        .POS_Y (yy)
      ) u_router (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_link_i   (r_in[N]),
        .in_ready_o  (r_in_rdy[N]),
        .out_link_o  (r_out[N]),
        .out_ready_i (r_out_rdy[N])
      );

      assign r_in[N][mesh_pkg::PORT_LOCAL]      = local_in_i[N];
      assign local_ready_o[N]                   = r_in_rdy[N][mesh_pkg::PORT_LOCAL];
      assign local_out_o[N]                     = r_out[N][mesh_pkg::PORT_LOCAL];
      assign r_out_rdy[N][mesh_pkg::PORT_LOCAL] = local_ready_i[N];

      // edges: nothing comes in, nothing may leave.
      if (xx < `MESH_X - 1) begin : g_east
        assign r_in[N][mesh_pkg::PORT_EAST]      = r_out[N+1][mesh_pkg::PORT_WEST];
        assign r_out_rdy[N][mesh_pkg::PORT_EAST] = r_in_rdy[N+1][mesh_pkg::PORT_WEST];
      end else begin : g_east_edge
        assign r_in[N][mesh_pkg::PORT_EAST]      = '0;
        assign r_out_rdy[N][mesh_pkg::PORT_EAST] = 1'b0;
      end

      if (xx > 0) begin : g_west
        assign r_in[N][mesh_pkg::PORT_WEST]      = r_out[N-1][mesh_pkg::PORT_EAST];
        assign r_out_rdy[N][mesh_pkg::PORT_WEST] = r_in_rdy[N-1][mesh_pkg::PORT_EAST];
      end else begin : g_west_edge
        assign r_in[N][mesh_pkg::PORT_WEST]      = '0;
        assign r_out_rdy[N][mesh_pkg::PORT_WEST] = 1'b0;
      end

      if (yy < `MESH_Y - 1) begin : g_north
        assign r_in[N][mesh_pkg::PORT_NORTH] = r_out[N+`MESH_X][mesh_pkg::PORT_SOUTH];
        assign r_out_rdy[N][mesh_pkg::PORT_NORTH] =
          r_in_rdy[N+`MESH_X][mesh_pkg::PORT_SOUTH];
      end else begin : g_north_edge
        assign r_in[N][mesh_pkg::PORT_NORTH]      = '0;
        assign r_out_rdy[N][mesh_pkg::PORT_NORTH] = 1'b0;
      end

      if (yy > 0) begin : g_south
        assign r_in[N][mesh_pkg::PORT_SOUTH] = r_out[N-`MESH_X][mesh_pkg::PORT_NORTH];
        assign r_out_rdy[N][mesh_pkg::PORT_SOUTH] =
          r_in_rdy[N-`MESH_X][mesh_pkg::PORT_NORTH];
      end else begin : g_south_edge
        assign r_in[N][mesh_pkg::PORT_SOUTH]      = '0;
        assign r_out_rdy[N][mesh_pkg::PORT_SOUTH] = 1'b0;
      end
    end
  end

endmodule

// File: design/mem_tile.sv
`timescale 1ns/100ps
`include "mesh_config.svh"

module mem_tile #(
  parameter int NODE_ID = 1
) (
  input  logic            clk,
  input  logic            reset_i,
  input  mesh_pkg::link_t req_i,
  output logic            req_ready_o,
  output mesh_pkg::link_t rsp_o,
  input  logic            rsp_ready_i
);

  typedef enum logic [2:0] {
    S_REQ_HDR,
    S_REQ_DATA,
    S_MEM,
    S_RSP_HDR,
    S_RSP_DATA
  } state_e;

  state_e              state_q;
  mesh_pkg::flit_hdr_t hdr_q;
  logic [31:0]         wdata_q;
  logic [31:0]         rdata_q;
  logic [31:0]         mem_q [`MEM_WORDS];
  mesh_pkg::flit_hdr_t rsp_hdr;
  logic                is_write;

  assign is_write    = hdr_q.kind == mesh_pkg::PKT_WR_REQ;
  assign req_ready_o = (state_q == S_REQ_HDR) || (state_q == S_REQ_DATA);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_REQ_HDR;
    end else begin
      case (state_q)
        S_REQ_HDR:  if (req_i.valid) state_q <= S_REQ_DATA;
        S_REQ_DATA: if (req_i.valid) state_q <= S_MEM;
        S_MEM:      state_q <= S_RSP_HDR;
        S_RSP_HDR:  if (rsp_ready_i) state_q <= S_RSP_DATA;
        S_RSP_DATA: if (rsp_ready_i) state_q <= S_REQ_HDR;
        default:    state_q <= S_REQ_HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready_o && req_i.valid) begin
      if (state_q == S_REQ_HDR) hdr_q <= req_i.flit.payload.hdr;
      else wdata_q <= req_i.flit.payload.data;
    end
    if (state_q == S_MEM) begin
      if (is_write) mem_q[hdr_q.addr] <= wdata_q;
      rdata_q <= mem_q[hdr_q.addr];
    end
  end

  // reply goes back to whoever asked.
  always_comb begin
    rsp_hdr       = '0;
    rsp_hdr.dst_x = hdr_q.src_x;
    rsp_hdr.dst_y = hdr_q.src_y;
    rsp_hdr.src_x = 1'(NODE_ID % `MESH_X);
    rsp_hdr.src_y = 1'(NODE_ID / `MESH_X);
    rsp_hdr.kind  = is_write ? mesh_pkg::PKT_WR_RSP : mesh_pkg::PKT_RD_RSP;
    rsp_hdr.addr  = hdr_q.addr;

    rsp_o       = '0;
    rsp_o.valid = (state_q == S_RSP_HDR) || (state_q == S_RSP_DATA);
    if (state_q == S_RSP_DATA) begin
      rsp_o.flit.payload.data = is_write ? '0 : rdata_q;
      rsp_o.flit.last         = 1'b1;
    end else begin
      rsp_o.flit.payload.hdr = rsp_hdr;
    end
  end

endmodule

// File: design/host_bridge.sv
`timescale 1ns/100ps
`include "mesh_config.svh"

module host_bridge (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`APB_AW-1:0] paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  output mesh_pkg::link_t    req_o,
  input  logic               req_ready_i,
  input  mesh_pkg::link_t    rsp_i,
  output logic               rsp_ready_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_HDR,
    S_DATA,
    S_WAIT,
    S_DONE
  } state_e;

  state_e                state_q;
  logic [`NODE_BITS-1:0] node;
  logic                  access;
  logic                  local_hit; // node 0 is the bridge itself.
  mesh_pkg::pkt_kind_e   rsp_kind;
  mesh_pkg::flit_hdr_t   req_hdr;
  logic [31:0]           rdata_q;
  logic                  kind_ok_q;

  assign node        = paddr_i[`APB_AW-1 -: `NODE_BITS];
  assign access      = psel_i & penable_i;
  assign local_hit   = node == '0;
  assign rsp_kind    = pwrite_i ? mesh_pkg::PKT_WR_RSP : mesh_pkg::PKT_RD_RSP;
  assign rsp_ready_o = state_q == S_WAIT;

  // source stays (0,0).
  always_comb begin
    req_hdr       = '0;
    req_hdr.dst_x = 1'(node % `MESH_X);
    req_hdr.dst_y = 1'(node / `MESH_X);
    req_hdr.kind  = pwrite_i ? mesh_pkg::PKT_WR_REQ : mesh_pkg::PKT_RD_REQ;
    req_hdr.addr  = paddr_i[2 +: $clog2(`MEM_WORDS)];
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE:  if (access && !local_hit) state_q <= S_HDR;
        S_HDR:   if (req_ready_i) state_q <= S_DATA;
        S_DATA:  if (req_ready_i) state_q <= S_WAIT;
        S_WAIT:  if (rsp_i.valid && rsp_i.flit.last) state_q <= S_DONE;
        S_DONE:  state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_WAIT && rsp_i.valid) begin
      if (rsp_i.flit.last) rdata_q <= rsp_i.flit.payload.data;
      else kind_ok_q <= rsp_i.flit.payload.hdr.kind == rsp_kind;
    end
  end

  // paddr and pwdata stay stable through the access phase.
  always_comb begin
    req_o       = '0;
    req_o.valid = (state_q == S_HDR) || (state_q == S_DATA);
    if (state_q == S_DATA) begin
      req_o.flit.payload.data = pwrite_i ? pwdata_i : '0;
      req_o.flit.last         = 1'b1;
    end else begin
      req_o.flit.payload.hdr = req_hdr;
    end
  end

  always_comb begin
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    prdata_o  = '0;
    if (state_q == S_DONE) begin
      pready_o  = 1'b1;
      pslverr_o = ~kind_ok_q;
      prdata_o  = rdata_q;
    end else if (state_q == S_IDLE && access && local_hit) begin
      pready_o  = 1'b1; // rejected at once.
      pslverr_o = 1'b1;
    end
  end

endmodule

// File: design/mpsoc_mesh.sv
`timescale 1ns/100ps
`include "mesh_config.svh"

module mpsoc_mesh (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`APB_AW-1:0] paddr_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o
);

  localparam int NODES = `MESH_X * `MESH_Y;

  // tiles to mesh.
  mesh_pkg::link_t [NODES-1:0] link_out;
  logic [NODES-1:0]            link_out_ready;
  // mesh to tiles.
  mesh_pkg::link_t [NODES-1:0] link_in;
  logic [NODES-1:0]            link_in_ready;

  host_bridge u_host_bridge (
    .clk         (clk),
    .reset_i     (reset_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .req_o       (link_out[0]),
    .req_ready_i (link_out_ready[0]),
    .rsp_i       (link_in[0]),
    .rsp_ready_o (link_in_ready[0])
  );

  noc_mesh u_noc_mesh (
    .clk           (clk),
    .reset_i       (reset_i),
    .local_in_i    (link_out),
    .local_ready_o (link_out_ready),
    .local_out_o   (link_in),
    .local_ready_i (link_in_ready)
  );

  for (genvar i = 1; i < NODES; i++) begin : g_tile
    mem_tile #(
      .NODE_ID (i)
    ) u_mem_tile (
      .clk         (clk),
      .reset_i     (reset_i),
      .req_i       (link_in[i]),
      .req_ready_o (link_in_ready[i]),
      .rsp_o       (link_out[i]),
      .rsp_ready_i (link_out_ready[i])
    );
  end

endmodule

// File: tests/mpsoc_mesh_assert.sv
`timescale 1ns/100ps

module mpsoc_mesh_assert #(
  parameter int NLINK     = 5,
  parameter bit APB_CHECK = 1'b0
) (
  input logic                        clk,
  input logic                        reset_i,
  input mesh_pkg::link_t [NLINK-1:0] link_i,
  input logic [NLINK-1:0]            ready_i,
  input logic                        psel_i,
  input logic                        penable_i,
  input logic                        pready_i
);

  logic in_reset_q = 1'b0; // high from the second reset cycle on.

  always @(posedge clk) in_reset_q <= reset_i;

  for (genvar k = 0; k < NLINK; k++) begin : g_link
    a_flit_hold: assert property (@(posedge clk) disable iff (reset_i)
      link_i[k].valid && !ready_i[k] |=> link_i[k].valid && $stable(link_i[k].flit))
      else $error("flit on link %0d changed before it was accepted", k);

    a_reset_idle: assert property (@(posedge clk)
      reset_i && in_reset_q |-> !link_i[k].valid)
      else $error("link %0d valid during reset", k);
  end

  if (APB_CHECK) begin : g_apb
    a_pready_access: assert property (@(posedge clk) disable iff (reset_i)
      pready_i |-> psel_i && penable_i)
      else $error("pready high outside an access phase");
  end

endmodule

// File: tests/mesh_checker.sv
`timescale 1ns/100ps
`include "mesh_config.svh"

module mesh_checker (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [`APB_AW-1:0] paddr_i,
  input  logic [31:0]        pwdata_i,
  input  logic [31:0]        prdata_i,
  input  logic               pready_i,
  input  logic               pslverr_i,
  input  logic               exp_err_i,
  output int                 tests_o,
  output int                 errors_o
);

  localparam int NODES = 1 << `NODE_BITS;

  logic [31:0]           model [NODES][`MEM_WORDS];
  logic                  known [NODES][`MEM_WORDS]; // word written at least once.
  logic [`NODE_BITS-1:0] node;
  logic [5:0]            word;
  int                    tests_q = 0;
  int                    errors_q = 0;

  assign node     = paddr_i[`APB_AW-1 -: `NODE_BITS];
  assign word     = paddr_i[2 +: 6];
  assign tests_o  = tests_q;
  assign errors_o = errors_q;

  always @(posedge clk) begin : check_transfer
    logic fail;
    if (reset_i) begin
      for (int n = 0; n < NODES; n++) begin
        for (int w = 0; w < `MEM_WORDS; w++) begin
          known[n][w] <= 1'b0;
        end
      end
    end else if (psel_i && penable_i && pready_i) begin
      fail = 1'b0;
      if (pslverr_i !== exp_err_i) begin
        $display("mismatch at time %0d ns: node %0d word %0d pslverr %b, expected %b",
                 $time, node, word, pslverr_i, exp_err_i);
        fail = 1'b1;
      end
      if (exp_err_i) begin
        if (prdata_i !== 32'h0) begin
          $display("mismatch at time %0d ns: node %0d prdata %h, expected 0",
                   $time, node, prdata_i);
          fail = 1'b1;
        end
      end else if (pwrite_i) begin
        model[node][word] <= pwdata_i;
        known[node][word] <= 1'b1;
      end else if (!known[node][word]) begin
        $display("test %0d reads node %0d word %0d, which no earlier test wrote",
                 tests_q + 1, node, word);
        fail = 1'b1;
      end else if (prdata_i !== model[node][word]) begin
        $display("mismatch at time %0d ns: node %0d word %0d read %h, expected %h",
                 $time, node, word, prdata_i, model[node][word]);
        fail = 1'b1;
      end
      $display("test %0d: %s node %0d word %0d %s", tests_q + 1,
               pwrite_i ? "write" : "read", node, word, fail ? "failed" : "ok");
      tests_q <= tests_q + 1;
      if (fail) errors_q <= errors_q + 1;
    end
  end

endmodule

// File: tests/mpsoc_mesh_tb.sv
`timescale 1ns/100ps
`include "mesh_config.svh"

module mpsoc_mesh_tb;

  localparam int          FIXED_TESTS    = 19;
  localparam int          RANDOM_TESTS   = 20;
  localparam int          N_TESTS        = FIXED_TESTS + RANDOM_TESTS;
  localparam int          TIMEOUT_CYCLES = 60 * N_TESTS + 4; // plus reset.
  localparam logic [31:0] SEED           = 32'h5bf4cf88;

  typedef struct packed {
    logic        wr;
    logic [1:0]  node;
    logic [5:0]  word;
    logic [31:0] data;
    logic        err;
  } stim_t;

  logic               clk;
  logic               reset;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [`APB_AW-1:0] paddr;
  logic [31:0]        pwdata;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;
  logic               exp_err;
  int                 tests_done;
  int                 tests_failed;
  int                 cycle_count;
  stim_t              tests [N_TESTS];

  mpsoc_mesh u_mpsoc_mesh (
    .clk       (clk),
    .reset_i   (reset),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  mesh_checker u_mesh_checker (
    .clk       (clk),
    .reset_i   (reset),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_i  (prdata),
    .pready_i  (pready),
    .pslverr_i (pslverr),
    .exp_err_i (exp_err),
    .tests_o   (tests_done),
    .errors_o  (tests_failed)
  );

  // router outputs, then the bridge and tile outputs plus APB at the top.
  bind noc_router mpsoc_mesh_assert #(.NLINK(5)) u_router_assert (
    .clk (clk), .reset_i (reset_i), .link_i (out_link_o), .ready_i (out_ready_i),
    .psel_i (1'b0), .penable_i (1'b0), .pready_i (1'b0)
  );
  bind mpsoc_mesh mpsoc_mesh_assert #(.NLINK(4), .APB_CHECK(1'b1)) u_top_assert (
    .clk (clk), .reset_i (reset_i), .link_i (link_out), .ready_i (link_out_ready),
    .psel_i (psel_i), .penable_i (penable_i), .pready_i (pready_o)
  );

  function automatic stim_t make_stim(logic wr, logic [1:0] node, logic [5:0] word,
                                      logic [31:0] data, logic err);
    stim_t s;
    s.wr   = wr;
    s.node = node;
    s.word = word;
    s.data = data;
    s.err  = err;
    return s;
  endfunction

  task automatic fill_table();
    logic [7:0] written_q [$]; // {node, word} of every random write.
    logic [7:0] pick;
    logic [1:0] node;
    logic [5:0] word;
    int         idx;
    // one and two hops.
    tests[0]  = make_stim(1'b1, 2'd1, 6'd5, 32'h1111_0005, 1'b0);
    tests[1]  = make_stim(1'b0, 2'd1, 6'd5, 32'h0, 1'b0);
    tests[2]  = make_stim(1'b1, 2'd2, 6'd9, 32'h2222_0009, 1'b0);
    tests[3]  = make_stim(1'b0, 2'd2, 6'd9, 32'h0, 1'b0);
    tests[4]  = make_stim(1'b1, 2'd3, 6'd17, 32'h3333_0011, 1'b0);
    tests[5]  = make_stim(1'b0, 2'd3, 6'd17, 32'h0, 1'b0);
    // same word on every tile.
    tests[6]  = make_stim(1'b1, 2'd1, 6'd30, 32'haaaa_0001, 1'b0);
    tests[7]  = make_stim(1'b1, 2'd2, 6'd30, 32'hbbbb_0002, 1'b0);
    tests[8]  = make_stim(1'b1, 2'd3, 6'd30, 32'hcccc_0003, 1'b0);
    tests[9]  = make_stim(1'b0, 2'd1, 6'd30, 32'h0, 1'b0);
    tests[10] = make_stim(1'b0, 2'd2, 6'd30, 32'h0, 1'b0);
    tests[11] = make_stim(1'b0, 2'd3, 6'd30, 32'h0, 1'b0);
    tests[12] = make_stim(1'b1, 2'd2, 6'd9, 32'h2222_9999, 1'b0); // overwrite.
    tests[13] = make_stim(1'b0, 2'd2, 6'd9, 32'h0, 1'b0);
    tests[14] = make_stim(1'b1, 2'd3, 6'd63, 32'h0bad_f00d, 1'b0);
    tests[15] = make_stim(1'b1, 2'd3, 6'd63, 32'h600d_cafe, 1'b0);
    tests[16] = make_stim(1'b0, 2'd3, 6'd63, 32'h0, 1'b0);
    tests[17] = make_stim(1'b0, 2'd0, 6'd3, 32'h0, 1'b1); // node 0 is rejected.
    tests[18] = make_stim(1'b1, 2'd0, 6'd4, 32'hdead_beef, 1'b1);
    for (int i = FIXED_TESTS; i < N_TESTS; i++) begin
      if (written_q.size() == 0 || ($urandom % 2) == 0) begin
        node     = 2'(1 + $urandom % 3);
        word     = 6'($urandom % `MEM_WORDS);
        tests[i] = make_stim(1'b1, node, word, $urandom, 1'b0);
        written_q.push_back({node, word});
      end else begin
        idx      = int'($urandom % 32'(written_q.size()));
        pick     = written_q[idx];
        tests[i] = make_stim(1'b0, pick[7:6], pick[5:0], 32'h0, 1'b0);
      end
    end
  endtask

  task automatic apb_transfer(input stim_t s);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= s.wr;
    paddr   <= {s.node, s.word, 2'b00};
    pwdata  <= s.wr ? s.data : 32'h0;
    exp_err <= s.err;
    @(posedge clk);
    penable <= 1'b1;
    do begin
      @(posedge clk);
    end while (!pready);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int seed_ret;
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    exp_err  = 1'b0;
    seed_ret = $urandom(SEED);
    fill_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int t = 0; t < N_TESTS; t++) begin
      apb_transfer(tests[t]);
    end
    @(posedge clk);
    if (tests_done != N_TESTS) begin
      $display("only %0d of %0d transfers reached the checker", tests_done, N_TESTS);
    end
    $display("%0d tests run, %0d failed", tests_done, tests_failed);
    if (tests_failed == 0 && tests_done == N_TESTS) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+design
design/mesh_pkg.sv
design/noc_router.sv
design/noc_mesh.sv
design/mem_tile.sv
design/host_bridge.sv
design/mpsoc_mesh.sv
tests/mpsoc_mesh_assert.sv
tests/mesh_checker.sv
tests/mpsoc_mesh_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mpsoc_mesh_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= CHECKS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
